// File: mdp_cfg_pkg.sv
`default_nettype none

package mdp_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // pipeline widths
    // ~~~~~~~~~~~~~~~~~~~~

    parameter int RENAME_WIDTH      = 2;   // lanes per rename group.
    parameter int STORE_ISSUE_WIDTH = 1;   // stores issued per cycle.
    parameter int READ_WIDTH        = 2;   // iq dispatch read ports.

    // ~~~~~~~~~~~~~~~~~~~~
    // backend sizes
    // ~~~~~~~~~~~~~~~~~~~~

    parameter int ROB_SIZE     = 32;
    parameter int FOLDPC_WIDTH = 10;       // pc after xor folding.

    // ~~~~~~~~~~~~~~~~~~~~
    // predictor tables
    // ~~~~~~~~~~~~~~~~~~~~

    // ssit is indexed by the low fold pc bits.
    parameter int DEF_SSIT_SIZE = 64;

    // one lfst entry per store set.
    parameter int DEF_LFST_SIZE = 16;

endpackage

`default_nettype wire

// File: mdp_types_pkg.sv
`default_nettype none

package mdp_types_pkg;

    import mdp_cfg_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // backend handles
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;

    typedef logic [FOLDPC_WIDTH-1:0] fold_pc_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // predictor types
    // ~~~~~~~~~~~~~~~~~~~~

    // store-set id, also the lfst index.
    typedef logic [$clog2(DEF_LFST_SIZE)-1:0] ssid_t;

    // one bit per rename lane.
    typedef logic [RENAME_WIDTH-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: mdp_dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mdp_dispatch_if;

    import mdp_cfg_pkg::*;
    import mdp_types_pkg::*;

    // dispatch group entering the backend.
    lane_mask_t insert_valid;
    lane_mask_t insert_store;                    // subset of insert_valid.
    rob_idx_t   alloc_rob_idx [RENAME_WIDTH];

    // dependence answer.
    lane_mask_t should_wait;
    rob_idx_t   dep_rob_idx [RENAME_WIDTH];      // zero when not waiting.

    modport source (
        output insert_valid,
        output insert_store,
        output alloc_rob_idx,
        input  should_wait,
        input  dep_rob_idx
    );

    modport sink (
        input  insert_valid,
        input  insert_store,
        input  alloc_rob_idx,
        output should_wait,
        output dep_rob_idx
    );

endinterface

`default_nettype wire

// File: store_set.sv
`timescale 1ns/1ps
`default_nettype none

module store_set #(
    parameter int SSIT_SIZE = mdp_cfg_pkg::DEF_SSIT_SIZE,
    parameter int LFST_SIZE = mdp_cfg_pkg::DEF_LFST_SIZE
) (
    input  wire                                    clk,
    input  wire                                    i_arst_n,
    input  wire                                    i_stall,

    // rename stage lookup.
    input  wire mdp_types_pkg::lane_mask_t         i_lookup_valid,
    input  wire mdp_types_pkg::fold_pc_t           i_fold_pc [mdp_cfg_pkg::RENAME_WIDTH],

    mdp_dispatch_if.sink                           dispatch,

    // store issue.
    input  wire [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issued,
    input  wire mdp_types_pkg::fold_pc_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_issue_fold_pc,
    input  wire mdp_types_pkg::rob_idx_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_rob_idx,

    // ordering violation.
    input  wire                                    i_violation,
    input  wire mdp_types_pkg::fold_pc_t           i_vio_store_fold_pc,
    input  wire mdp_types_pkg::fold_pc_t           i_vio_load_fold_pc
);

    import mdp_cfg_pkg::*;
    import mdp_types_pkg::*;

    localparam int SSIT_IDX_W = $clog2(SSIT_SIZE);
    localparam int SSID_W     = $bits(ssid_t);

    typedef logic [SSIT_IDX_W-1:0] ssit_idx_t;

    function automatic ssit_idx_t ssit_idx(fold_pc_t pc);
        return pc[SSIT_IDX_W-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // tables
    // ~~~~~~~~~~~~~~~~~~~~

    logic [SSIT_SIZE-1:0] ssit_vld;
    ssid_t                ssit_ssid [SSIT_SIZE];

    logic [LFST_SIZE-1:0] lfst_vld;
    rob_idx_t             lfst_rob_idx [LFST_SIZE];   // newest store of the set.

    lane_mask_t lk_hit;                 // registered lookup.
    ssid_t      lk_ssid [RENAME_WIDTH];

    lane_mask_t                   store_wr;
    logic [STORE_ISSUE_WIDTH-1:0] iss_release;
    ssid_t                        iss_ssid [STORE_ISSUE_WIDTH];

    ssit_idx_t vio_st_idx;
    ssit_idx_t vio_ld_idx;
    ssid_t     vio_ssid;

    // ~~~~~~~~~~~~~~~~~~~~
    // rename lookup
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lk_hit <= '0;
        end else if (!i_stall) begin
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                lk_hit[k] <= i_lookup_valid[k] && ssit_vld[ssit_idx(i_fold_pc[k])];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                lk_ssid[k] <= ssit_ssid[ssit_idx(i_fold_pc[k])];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // dispatch check
    // ~~~~~~~~~~~~~~~~~~~~

    assign store_wr = dispatch.insert_valid & dispatch.insert_store & lk_hit;

    always_comb begin
        logic     wait_k;
        rob_idx_t dep_k;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            wait_k = lk_hit[k] && lfst_vld[lk_ssid[k]];
            dep_k  = lfst_rob_idx[lk_ssid[k]];
            // an older store in the group is newer than the lfst entry.
            for (int j = 0; j < k; j++) begin
                if (store_wr[j] && lk_hit[k] && (lk_ssid[j] == lk_ssid[k])) begin
                    wait_k = 1'b1;
                    dep_k  = dispatch.alloc_rob_idx[j];
                end
            end
            dispatch.should_wait[k] = dispatch.insert_valid[k] && wait_k;
            dispatch.dep_rob_idx[k] = dispatch.should_wait[k] ? dep_k : '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // lfst update
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int s = 0; s < STORE_ISSUE_WIDTH; s++) begin
            iss_ssid[s]    = ssit_ssid[ssit_idx(i_issue_fold_pc[s])];
            iss_release[s] = i_store_issued[s] && ssit_vld[ssit_idx(i_issue_fold_pc[s])] &&
                             lfst_vld[iss_ssid[s]] &&
                             (lfst_rob_idx[iss_ssid[s]] == i_store_rob_idx[s]);
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lfst_vld <= '0;
        end else if (i_violation) begin
            lfst_vld <= '0;
        end else begin
            for (int s = 0; s < STORE_ISSUE_WIDTH; s++) begin
                if (iss_release[s]) begin
                    lfst_vld[iss_ssid[s]] <= 1'b0;
                end
            end
            for (int k = 0; k < RENAME_WIDTH; k++) begin  // new store beats release.
                if (store_wr[k]) begin
                    lfst_vld[lk_ssid[k]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            if (store_wr[k]) begin
                lfst_rob_idx[lk_ssid[k]] <= dispatch.alloc_rob_idx[k];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ssit training
    // ~~~~~~~~~~~~~~~~~~~~

    assign vio_st_idx = ssit_idx(i_vio_store_fold_pc);
    assign vio_ld_idx = ssit_idx(i_vio_load_fold_pc);

    // store id first, then load id, else a fresh one from the store pc.
    assign vio_ssid = ssit_vld[vio_st_idx] ? ssit_ssid[vio_st_idx] :
                      ssit_vld[vio_ld_idx] ? ssit_ssid[vio_ld_idx] :
                      ssid_t'(i_vio_store_fold_pc[SSID_W-1:0]);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ssit_vld <= '0;
        end else if (i_violation) begin
            ssit_vld[vio_st_idx] <= 1'b1;
            ssit_vld[vio_ld_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_violation) begin
            ssit_ssid[vio_st_idx] <= vio_ssid;
            ssit_ssid[vio_ld_idx] <= vio_ssid;
        end
    end

endmodule

`default_nettype wire

// File: store_ready_table.sv
`timescale 1ns/1ps
`default_nettype none

module store_ready_table (
    input  wire                                      clk,
    input  wire                                      i_arst_n,
    input  wire                                      i_violation,

    // only the insert side of the bundle is used here.
    mdp_dispatch_if.source                           dispatch,

    input  wire [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issued,
    input  wire mdp_types_pkg::rob_idx_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_rob_idx,

    input  wire mdp_types_pkg::rob_idx_t             i_read_rob_idx [mdp_cfg_pkg::READ_WIDTH],
    output logic [mdp_cfg_pkg::READ_WIDTH-1:0]       o_memdep_rdy
);

    import mdp_cfg_pkg::*;
    import mdp_types_pkg::*;

    logic [ROB_SIZE-1:0] rdy_bits;    // 1 = no pending store.
    logic [ROB_SIZE-1:0] ins_clr;
    logic [ROB_SIZE-1:0] issue_set;

    // ~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ins_clr = '0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            if (dispatch.insert_valid[k] && dispatch.insert_store[k]) begin
                ins_clr[dispatch.alloc_rob_idx[k]] = 1'b1;
            end
        end
    end

    always_comb begin
        issue_set = '0;
        for (int s = 0; s < STORE_ISSUE_WIDTH; s++) begin
            if (i_store_issued[s]) begin
                issue_set[i_store_rob_idx[s]] = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ready bits
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rdy_bits <= '1;
        end else if (i_violation) begin
            rdy_bits <= '1;                      // flushed stores never issue.
        end else begin
            rdy_bits <= (rdy_bits & ~ins_clr) | issue_set;
        end
    end

    // bypass so a waiter sees this cycle's issue.
    always_comb begin
        for (int j = 0; j < READ_WIDTH; j++) begin
            o_memdep_rdy[j] = rdy_bits[i_read_rob_idx[j]] | issue_set[i_read_rob_idx[j]];
        end
    end

endmodule

`default_nettype wire

// File: mem_dep_pred.sv
`timescale 1ns/1ps
`default_nettype none

module mem_dep_pred #(
    parameter int SSIT_SIZE = mdp_cfg_pkg::DEF_SSIT_SIZE,
    parameter int LFST_SIZE = mdp_cfg_pkg::DEF_LFST_SIZE
) (
    input  wire                                      clk,
    input  wire                                      i_arst_n,
    input  wire                                      i_stall,

    // rename
    input  wire mdp_types_pkg::lane_mask_t           i_lookup_valid,
    input  wire mdp_types_pkg::fold_pc_t             i_fold_pc [mdp_cfg_pkg::RENAME_WIDTH],

    // dispatch
    input  wire mdp_types_pkg::lane_mask_t           i_insert_valid,
    input  wire mdp_types_pkg::lane_mask_t           i_insert_store,
    input  wire mdp_types_pkg::rob_idx_t             i_alloc_rob_idx [mdp_cfg_pkg::RENAME_WIDTH],
    output wire mdp_types_pkg::lane_mask_t           o_should_wait,
    output wire mdp_types_pkg::rob_idx_t             o_dep_rob_idx [mdp_cfg_pkg::RENAME_WIDTH],

    // store issue
    input  wire [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issued,
    input  wire mdp_types_pkg::fold_pc_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_issue_fold_pc,
    input  wire mdp_types_pkg::rob_idx_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_rob_idx,

    // violation
    input  wire                                      i_violation,
    input  wire mdp_types_pkg::fold_pc_t             i_vio_store_fold_pc,
    input  wire mdp_types_pkg::fold_pc_t             i_vio_load_fold_pc,

    // iq dispatch ready read
    input  wire mdp_types_pkg::rob_idx_t             i_read_rob_idx [mdp_cfg_pkg::READ_WIDTH],
    output wire [mdp_cfg_pkg::READ_WIDTH-1:0]        o_memdep_rdy
);

    mdp_dispatch_if u_dispatch_if ();

    // plain ports onto the dispatch bundle.
    assign u_dispatch_if.insert_valid  = i_insert_valid;
    assign u_dispatch_if.insert_store  = i_insert_store;
    assign u_dispatch_if.alloc_rob_idx = i_alloc_rob_idx;

    assign o_should_wait = u_dispatch_if.should_wait;
    assign o_dep_rob_idx = u_dispatch_if.dep_rob_idx;

    store_set #(
        .SSIT_SIZE ( SSIT_SIZE ),
        .LFST_SIZE ( LFST_SIZE )
    ) u_store_set (
        .clk                 ( clk                 ),
        .i_arst_n            ( i_arst_n            ),
        .i_stall             ( i_stall             ),
        .i_lookup_valid      ( i_lookup_valid      ),
        .i_fold_pc           ( i_fold_pc           ),
        .dispatch            ( u_dispatch_if.sink  ),
        .i_store_issued      ( i_store_issued      ),
        .i_issue_fold_pc     ( i_issue_fold_pc     ),
        .i_store_rob_idx     ( i_store_rob_idx     ),
        .i_violation         ( i_violation         ),
        .i_vio_store_fold_pc ( i_vio_store_fold_pc ),
        .i_vio_load_fold_pc  ( i_vio_load_fold_pc  )
    );

    // ready table watches the same insert traffic.
    store_ready_table u_store_ready_table (
        .clk             ( clk                  ),
        .i_arst_n        ( i_arst_n             ),
        .i_violation     ( i_violation          ),
        .dispatch        ( u_dispatch_if.source ),
        .i_store_issued  ( i_store_issued       ),
        .i_store_rob_idx ( i_store_rob_idx      ),
        .i_read_rob_idx  ( i_read_rob_idx       ),
        .o_memdep_rdy    ( o_memdep_rdy         )
    );

endmodule

`default_nettype wire

// File: mem_dep_pred_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_dep_pred_checker (
    input  wire                                      clk,
    input  wire                                      i_arst_n,
    input  wire mdp_types_pkg::lane_mask_t           i_insert_valid,
    input  wire mdp_types_pkg::lane_mask_t           i_insert_store,
    input  wire mdp_types_pkg::rob_idx_t             i_alloc_rob_idx [mdp_cfg_pkg::RENAME_WIDTH],
    input  wire mdp_types_pkg::lane_mask_t           i_should_wait,
    input  wire mdp_types_pkg::rob_idx_t             i_dep_rob_idx [mdp_cfg_pkg::RENAME_WIDTH],
    input  wire [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issued,
    input  wire mdp_types_pkg::rob_idx_t [mdp_cfg_pkg::STORE_ISSUE_WIDTH-1:0] i_store_rob_idx,
    input  wire                                      i_violation,
    input  wire [mdp_cfg_pkg::READ_WIDTH-1:0]        i_memdep_rdy,
    input  wire [mdp_cfg_pkg::ROB_SIZE-1:0]          i_rdy_bits
);

    import mdp_cfg_pkg::*;
    import mdp_types_pkg::*;

    int fail_cnt = 0;

    // an older store lane of this group with the given rob index.
    function automatic logic older_store_in_group(int k, rob_idx_t idx);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < k; j++) begin
            if (i_insert_valid[j] && i_insert_store[j] && (i_alloc_rob_idx[j] == idx)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // a waiter must be a valid lane whose producer store is still pending.
    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_wait
        a_wait_on_pending: assert property (@(posedge clk) disable iff (!i_arst_n)
            i_should_wait[k] |-> (i_insert_valid[k] &&
                (!i_rdy_bits[i_dep_rob_idx[k]] || older_store_in_group(k, i_dep_rob_idx[k]))))
        else begin
            fail_cnt++;
            $error("should_wait on an idle lane or on a store that is not pending");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ready table
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_lane
        a_insert_on_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
            (i_insert_valid[k] && i_insert_store[k] && !i_violation)
            |-> i_rdy_bits[i_alloc_rob_idx[k]])
        else begin
            fail_cnt++;
            $error("store inserted over a pending ready bit");
        end
    end

    for (genvar s = 0; s < STORE_ISSUE_WIDTH; s++) begin : g_issue
        a_issue_was_pending: assert property (@(posedge clk) disable iff (!i_arst_n)
            (i_store_issued[s] && !i_violation) |-> !i_rdy_bits[i_store_rob_idx[s]])
        else begin
            fail_cnt++;
            $error("issued store had no pending ready bit");
        end
    end

    a_flush_all_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_violation |=> (&i_memdep_rdy))
    else begin
        fail_cnt++;
        $error("ready read low right after a violation");
    end

endmodule

`default_nettype wire

// File: tb_mem_dep_pred.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_dep_pred;

    import mdp_cfg_pkg::*;
    import mdp_types_pkg::*;

    localparam int NUM_FIELDS = 20;
    localparam int MAX_LINES  = 200;
    localparam int RESET_TMO  = 20;     // cycles.

    logic                             clk;
    logic                             i_arst_n;
    logic                             i_stall;
    lane_mask_t                       i_lookup_valid;
    fold_pc_t                         i_fold_pc [RENAME_WIDTH];
    lane_mask_t                       i_insert_valid;
    lane_mask_t                       i_insert_store;
    rob_idx_t                         i_alloc_rob_idx [RENAME_WIDTH];
    lane_mask_t                       o_should_wait;
    rob_idx_t                         o_dep_rob_idx [RENAME_WIDTH];
    logic     [STORE_ISSUE_WIDTH-1:0] i_store_issued;
    fold_pc_t [STORE_ISSUE_WIDTH-1:0] i_issue_fold_pc;
    rob_idx_t [STORE_ISSUE_WIDTH-1:0] i_store_rob_idx;
    logic                             i_violation;
    fold_pc_t                         i_vio_store_fold_pc;
    fold_pc_t                         i_vio_load_fold_pc;
    rob_idx_t                         i_read_rob_idx [READ_WIDTH];
    logic [READ_WIDTH-1:0]            o_memdep_rdy;

    logic [15:0] fld [NUM_FIELDS];      // one parsed vector line.
    int          n_vec;

    mem_dep_pred #(
        .SSIT_SIZE ( DEF_SSIT_SIZE ),
        .LFST_SIZE ( DEF_LFST_SIZE )
    ) i_mem_dep_pred (.*);

    bind mem_dep_pred mem_dep_pred_checker u_checker (
        .clk             ( clk                            ),
        .i_arst_n        ( i_arst_n                       ),
        .i_insert_valid  ( i_insert_valid                 ),
        .i_insert_store  ( i_insert_store                 ),
        .i_alloc_rob_idx ( i_alloc_rob_idx                ),
        .i_should_wait   ( o_should_wait                  ),
        .i_dep_rob_idx   ( o_dep_rob_idx                  ),
        .i_store_issued  ( i_store_issued                 ),
        .i_store_rob_idx ( i_store_rob_idx                ),
        .i_violation     ( i_violation                    ),
        .i_memdep_rdy    ( o_memdep_rdy                   ),
        .i_rdy_bits      ( u_store_ready_table.rdy_bits   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        i_arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #5 i_arst_n = 1'b1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_lanes(input string name, input lane_mask_t got, input lane_mask_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h (vector %0d)", name, got, exp, n_vec));
        end
    endtask

    task automatic match_rob_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h (vector %0d)", name, got, exp, n_vec));
        end
    endtask

    task automatic verify_ready(input string name, input logic [READ_WIDTH-1:0] got,
                                input logic [READ_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h (vector %0d)", name, got, exp, n_vec));
        end
    endtask

    task automatic idle_inputs();
        i_stall             = 1'b0;
        i_lookup_valid      = '0;
        i_insert_valid      = '0;
        i_insert_store      = '0;
        i_store_issued      = '0;
        i_issue_fold_pc     = '0;
        i_store_rob_idx     = '0;
        i_violation         = 1'b0;
        i_vio_store_fold_pc = '0;
        i_vio_load_fold_pc  = '0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            i_fold_pc[k]       = '0;
            i_alloc_rob_idx[k] = '0;
        end
        for (int j = 0; j < READ_WIDTH; j++) begin
            i_read_rob_idx[j] = '0;
        end
    endtask

    // columns as in the data file header.
    task automatic drive_vector();
        i_stall             = fld[0][0];
        i_lookup_valid      = lane_mask_t'(fld[1]);
        i_fold_pc[0]        = fold_pc_t'(fld[2]);
        i_fold_pc[1]        = fold_pc_t'(fld[3]);
        i_insert_valid      = lane_mask_t'(fld[4]);
        i_insert_store      = lane_mask_t'(fld[5]);
        i_alloc_rob_idx[0]  = rob_idx_t'(fld[6]);
        i_alloc_rob_idx[1]  = rob_idx_t'(fld[7]);
        i_store_issued[0]   = fld[8][0];
        i_issue_fold_pc[0]  = fold_pc_t'(fld[9]);
        i_store_rob_idx[0]  = rob_idx_t'(fld[10]);
        i_violation         = fld[11][0];
        i_vio_store_fold_pc = fold_pc_t'(fld[12]);
        i_vio_load_fold_pc  = fold_pc_t'(fld[13]);
        i_read_rob_idx[0]   = rob_idx_t'(fld[14]);
        i_read_rob_idx[1]   = rob_idx_t'(fld[15]);
    endtask

    task automatic wait_reset_release();
        int tmo;
        tmo = 0;
        while (i_arst_n !== 1'b1) begin
            @(posedge clk);
            tmo++;
            if (tmo > RESET_TMO) begin
                abort_run("reset was never released");
            end
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    n_lines;
        string line;
        idle_inputs();
        n_vec   = 0;
        n_lines = 0;
        wait_reset_release();
        fd = $fopen("mem_dep_pred_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end
        while (!$feof(fd)) begin
            n_lines++;
            if (n_lines > MAX_LINES) begin
                abort_run("reading the test data did not finish in time");
            end
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9],
                fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16], fld[17],
                fld[18], fld[19]);
            if (code != NUM_FIELDS) begin
                abort_run($sformatf("test data line %0d has the wrong field count", n_lines));
            end
            @(posedge clk);
            #5;
            drive_vector();
            @(negedge clk);                 // outputs settled here.
            compare_lanes("o_should_wait", o_should_wait, lane_mask_t'(fld[16]));
            match_rob_idx("o_dep_rob_idx[0]", o_dep_rob_idx[0], rob_idx_t'(fld[17]));
            match_rob_idx("o_dep_rob_idx[1]", o_dep_rob_idx[1], rob_idx_t'(fld[18]));
            verify_ready("o_memdep_rdy", o_memdep_rdy, fld[19][READ_WIDTH-1:0]);
            if (i_mem_dep_pred.u_checker.fail_cnt != 0) begin
                abort_run($sformatf("a bound assertion failed near vector %0d", n_vec));
            end
            n_vec++;
        end
        $fclose(fd);
        @(posedge clk);
        #5 idle_inputs();
        @(negedge clk);
        if (n_vec == 0 || i_mem_dep_pred.u_checker.fail_cnt != 0) begin
            abort_run("no vectors were applied or a bound assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
mdp_cfg_pkg.sv
mdp_types_pkg.sv
mdp_dispatch_if.sv
store_set.sv
store_ready_table.sv
mem_dep_pred.sv
mem_dep_pred_checker.sv
tb_mem_dep_pred.sv

// File: Bender.yml
package:
  name: mem_dep_pred

sources:
  - mdp_cfg_pkg.sv
  - mdp_types_pkg.sv
  - mdp_dispatch_if.sv
  - store_set.sv
  - store_ready_table.sv
  - mem_dep_pred.sv
  - target: test
    files:
      - mem_dep_pred_checker.sv
      - tb_mem_dep_pred.sv

// File: mem_dep_pred_testdata.txt
# stl lkv pc0 pc1 iv st a0 a1 iss ipc irob vio vst vld rd0 rd1 | exp: sw dep0 dep1 rdy
# all hex, one line per cycle, mask bit k belongs to lane or port k
0 3 123 2a7 0 0 00 00 0 000 00 0 000 000 04 1f 0 00 00 3
0 0 000 000 3 1 04 05 0 000 00 0 000 000 04 05 0 00 00 3
0 0 000 000 0 0 00 00 0 000 00 0 000 000 04 05 0 00 00 2
0 0 000 000 0 0 00 00 0 000 00 1 123 2a7 04 05 0 00 00 2
0 1 123 000 0 0 00 00 0 000 00 0 000 000 04 05 0 00 00 3
0 1 2a7 000 1 1 08 00 0 000 00 0 000 000 08 09 0 00 00 3
0 0 000 000 1 0 09 00 0 000 00 0 000 000 08 09 1 08 00 2
0 1 2a7 000 0 0 00 00 1 123 08 0 000 000 08 09 0 00 00 3
0 0 000 000 1 0 0a 00 0 000 00 0 000 000 08 09 0 00 00 3
0 3 123 2a7 0 0 00 00 0 000 00 0 000 000 0c 0d 0 00 00 3
0 0 000 000 3 1 0c 0d 0 000 00 0 000 000 0c 0d 2 00 0c 3
0 1 123 000 0 0 00 00 0 000 00 0 000 000 0c 0d 0 00 00 2
0 1 2a7 000 1 1 0e 00 0 000 00 0 000 000 0c 0e 1 0c 00 2
0 0 000 000 1 0 0f 00 0 000 00 0 000 000 0e 0c 1 0e 00 0
0 1 2a7 000 0 0 00 00 1 123 0c 0 000 000 0c 0e 0 00 00 1
0 0 000 000 1 0 10 00 0 000 00 0 000 000 0c 0e 1 0e 00 1
0 3 2a7 011 0 0 00 00 0 000 00 0 000 000 0e 0c 0 00 00 2
1 3 011 123 0 0 00 00 0 000 00 0 000 000 0e 0c 0 00 00 2
1 0 000 000 0 0 00 00 0 000 00 0 000 000 0e 0c 0 00 00 2
0 0 000 000 3 0 11 12 0 000 00 0 000 000 0e 0c 1 0e 00 2
0 0 000 000 0 0 00 00 0 000 00 1 123 2a7 0e 0c 0 00 00 2
0 1 2a7 000 0 0 00 00 0 000 00 0 000 000 0e 04 0 00 00 3
0 1 123 000 1 0 13 00 0 000 00 0 000 000 13 14 0 00 00 3
0 1 2a7 000 1 1 14 00 0 000 00 0 000 000 14 13 0 00 00 3
0 0 000 000 1 0 15 00 0 000 00 0 000 000 14 15 1 14 00 2
0 0 000 000 0 0 00 00 1 123 14 0 000 000 14 15 0 00 00 3
0 0 000 000 0 0 00 00 0 000 00 0 000 000 14 0e 0 00 00 3
